// File: hw/line_pkg.sv
// line geometry shared by the line store, the formatter and the load path top
package line_pkg;

    // bytes held by one line
    localparam int LINE_BYTES = 16;

    // full line width in bits
    localparam int LINE_BITS = LINE_BYTES * 8;

    // byte offset within a line
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);

endpackage

// File: hw/load_pkg.sv
// load opcodes: access size encoding and fault causes of the load unit
package load_pkg;

    // access size of a load, 2'b11 is illegal
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

    // why a load was rejected at issue
    typedef enum logic {
        FAULT_SIZE  = 1'b0,
        FAULT_ALIGN = 1'b1
    } fault_cause_e;

endpackage

// File: hw/cache_read_formatter.sv
// line read formatter: picks a byte, halfword or word from a line and extends it to 32 bits
module cache_read_formatter (
    input  logic [line_pkg::LINE_BITS-1:0]   line_in,
    input  logic [line_pkg::OFFSET_BITS-1:0] offset,
    input  load_pkg::mem_size_e              size_type,
    input  logic                             sign_ext,
    output logic [31:0]                      data_out
);

    import line_pkg::*;
    import load_pkg::*;

    logic [31:0] selected_word;
    logic [7:0]  selected_byte;
    logic [15:0] selected_half;

    // upper offset bits pick the word within the line
    assign selected_word = line_in[offset[OFFSET_BITS-1:2] * 32 +: 32];

    // lower bits pick the byte or half inside that word
    assign selected_byte = selected_word[offset[1:0] * 8 +: 8];
    assign selected_half = selected_word[offset[1] * 16 +: 16];

    always_comb begin
        case (size_type)
            SIZE_BYTE: begin
                data_out = {{24{sign_ext & selected_byte[7]}}, selected_byte};
            end
            SIZE_HALF: begin
                data_out = {{16{sign_ext & selected_half[15]}}, selected_half};
            end
            SIZE_WORD: begin
                // full word, nothing to extend
                data_out = selected_word;
            end
            default: begin
                data_out = 32'b0;
            end
        endcase
    end

endmodule

// File: hw/load_issue.sv
// load issue register: checks size and alignment, pushes legal loads and flags faults
module load_issue #(
    parameter int LINES = 8
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           load_valid,
    input  logic [line_pkg::OFFSET_BITS+$clog2(LINES)-1:0] load_addr,
    input  load_pkg::mem_size_e                            load_size,
    input  logic                                           load_sign,
    output logic                                           push,
    output logic [$clog2(LINES)-1:0]                       push_index,
    output logic [line_pkg::OFFSET_BITS-1:0]               push_offset,
    output load_pkg::mem_size_e                            push_size,
    output logic                                           push_sign,
    output logic                                           fault_valid,
    output logic [line_pkg::OFFSET_BITS+$clog2(LINES)-1:0] fault_addr,
    output load_pkg::fault_cause_e                         fault_cause
);

    import line_pkg::*;
    import load_pkg::*;

    logic         size_bad;
    logic         align_bad;
    fault_cause_e cause;

    // the fourth size code has no meaning
    assign size_bad = !(load_size inside {SIZE_BYTE, SIZE_HALF, SIZE_WORD});

    always_comb begin
        align_bad = 1'b0;
        if (load_size == SIZE_HALF) begin
            align_bad = load_addr[0];
        end else if (load_size == SIZE_WORD) begin
            align_bad = |load_addr[1:0];
        end
    end

    // size problems take priority over alignment
    assign cause = size_bad ? FAULT_SIZE : FAULT_ALIGN;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push        <= 1'b0;
            fault_valid <= 1'b0;
        end else begin
            push        <= load_valid && !size_bad && !align_bad;
            fault_valid <= load_valid && (size_bad || align_bad);
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid) begin
            push_offset <= load_addr[OFFSET_BITS-1:0];
            push_index  <= load_addr[OFFSET_BITS +: $clog2(LINES)];
            push_size   <= load_size;
            push_sign   <= load_sign;
            fault_addr  <= load_addr;
            fault_cause <= cause;
        end
    end

endmodule

// File: hw/load_queue.sv
// load queue: circular FIFO of accepted loads with empty and ready levels
module load_queue #(
    parameter int QUEUE_DEPTH = 4,
    parameter int INDEX_W     = 3
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             push,
    input  logic [INDEX_W-1:0]               push_index,
    input  logic [line_pkg::OFFSET_BITS-1:0] push_offset,
    input  load_pkg::mem_size_e              push_size,
    input  logic                             push_sign,
    input  logic                             pop,
    output logic [INDEX_W-1:0]               head_index,
    output logic [line_pkg::OFFSET_BITS-1:0] head_offset,
    output load_pkg::mem_size_e              head_size,
    output logic                             head_sign,
    output logic                             empty,
    output logic                             ready
);

    import line_pkg::*;
    import load_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [INDEX_W-1:0]     index_mem  [QUEUE_DEPTH];
    logic [OFFSET_BITS-1:0] offset_mem [QUEUE_DEPTH];
    mem_size_e              size_mem   [QUEUE_DEPTH];
    logic                   sign_mem   [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wrap at the last entry, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            index_mem[wr_ptr]  <= push_index;
            offset_mem[wr_ptr] <= push_offset;
            size_mem[wr_ptr]   <= push_size;
            sign_mem[wr_ptr]   <= push_sign;
        end
    end

    assign head_index  = index_mem[rd_ptr];
    assign head_offset = offset_mem[rd_ptr];
    assign head_size   = size_mem[rd_ptr];
    assign head_sign   = sign_mem[rd_ptr];

    assign empty = (count == '0);
    // keep one slot spare for the load sitting in the issue register
    assign ready = (count <= CNT_W'(QUEUE_DEPTH - 2));

endmodule

// File: hw/line_store.sv
// line store: direct-mapped line array with whole-line fill and registered read
module line_store #(
    parameter int LINES = 8
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           fill_valid,
    input  logic [$clog2(LINES)-1:0]       fill_index,
    input  logic [line_pkg::LINE_BITS-1:0] fill_line,
    input  logic [$clog2(LINES)-1:0]       rd_index,
    output logic [line_pkg::LINE_BITS-1:0] rd_line
);

    import line_pkg::*;

    logic [LINE_BITS-1:0] lines [LINES];

    // a read in the fill cycle still returns the old line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LINES; i++) begin
                lines[i] <= '0;
            end
            rd_line <= '0;
        end else begin
            if (fill_valid) begin
                lines[fill_index] <= fill_line;
            end
            rd_line <= lines[rd_index];
        end
    end

endmodule

// File: hw/load_format_stage.sv
// format stage: pops queued loads, reads their lines and registers the formatted data
module load_format_stage #(
    parameter int LINES = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [$clog2(LINES)-1:0]         head_index,
    input  logic [line_pkg::OFFSET_BITS-1:0] head_offset,
    input  load_pkg::mem_size_e              head_size,
    input  logic                             head_sign,
    input  logic                             empty,
    input  logic [line_pkg::LINE_BITS-1:0]   rd_line,
    output logic                             pop,
    output logic [$clog2(LINES)-1:0]         rd_index,
    output logic                             result_valid,
    output logic [31:0]                      result_data
);

    import line_pkg::*;
    import load_pkg::*;

    logic                   s1_valid;
    logic [OFFSET_BITS-1:0] s1_offset;
    mem_size_e              s1_size;
    logic                   s1_sign;
    logic [31:0]            fmt_data;

    // no back-pressure downstream, so take the head whenever there is one
    assign pop      = !empty;
    assign rd_index = head_index;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= pop;
            result_valid <= s1_valid;
        end
    end

    // load fields ride along with the line read
    always_ff @(posedge clk) begin
        if (pop) begin
            s1_offset <= head_offset;
            s1_size   <= head_size;
            s1_sign   <= head_sign;
        end
        if (s1_valid) begin
            result_data <= fmt_data;
        end
    end

    cache_read_formatter u_formatter (
        .line_in   (rd_line),
        .offset    (s1_offset),
        .size_type (s1_size),
        .sign_ext  (s1_sign),
        .data_out  (fmt_data)
    );

endmodule

// File: hw/load_read_path.sv
// load read path: issue, queue, line store and format stage of the load unit
module load_read_path #(
    parameter int LINES       = 8,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           fill_valid,
    input  logic [$clog2(LINES)-1:0]                       fill_index,
    input  logic [line_pkg::LINE_BITS-1:0]                 fill_line,
    input  logic                                           load_valid,
    input  logic [line_pkg::OFFSET_BITS+$clog2(LINES)-1:0] load_addr,
    input  load_pkg::mem_size_e                            load_size,
    input  logic                                           load_sign,
    output logic                                           load_ready,
    output logic                                           result_valid,
    output logic [31:0]                                    result_data,
    output logic                                           fault_valid,
    output logic [line_pkg::OFFSET_BITS+$clog2(LINES)-1:0] fault_addr,
    output load_pkg::fault_cause_e                         fault_cause
);

    import line_pkg::*;
    import load_pkg::*;

    localparam int INDEX_W = $clog2(LINES);

    // issue to queue
    logic                   push;
    logic [INDEX_W-1:0]     push_index;
    logic [OFFSET_BITS-1:0] push_offset;
    mem_size_e              push_size;
    logic                   push_sign;

    // queue head to format stage
    logic                   pop;
    logic                   empty;
    logic [INDEX_W-1:0]     head_index;
    logic [OFFSET_BITS-1:0] head_offset;
    mem_size_e              head_size;
    logic                   head_sign;

    logic [INDEX_W-1:0]     rd_index;
    logic [LINE_BITS-1:0]   rd_line;

    load_issue #(
        .LINES (LINES)
    ) u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_size   (load_size),
        .load_sign   (load_sign),
        .push        (push),
        .push_index  (push_index),
        .push_offset (push_offset),
        .push_size   (push_size),
        .push_sign   (push_sign),
        .fault_valid (fault_valid),
        .fault_addr  (fault_addr),
        .fault_cause (fault_cause)
    );

    load_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .INDEX_W     (INDEX_W)
    ) u_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_index  (push_index),
        .push_offset (push_offset),
        .push_size   (push_size),
        .push_sign   (push_sign),
        .pop         (pop),
        .head_index  (head_index),
        .head_offset (head_offset),
        .head_size   (head_size),
        .head_sign   (head_sign),
        .empty       (empty),
        .ready       (load_ready)
    );

    line_store #(
        .LINES (LINES)
    ) u_line_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_valid (fill_valid),
        .fill_index (fill_index),
        .fill_line  (fill_line),
        .rd_index   (rd_index),
        .rd_line    (rd_line)
    );

    load_format_stage #(
        .LINES (LINES)
    ) u_format (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_index   (head_index),
        .head_offset  (head_offset),
        .head_size    (head_size),
        .head_sign    (head_sign),
        .empty        (empty),
        .rd_line      (rd_line),
        .pop          (pop),
        .rd_index     (rd_index),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

endmodule

// File: sim/load_read_path_assert.sv
// load queue checks: no push when full, no pop when empty, count in range, push only after ready
module load_read_path_assert #(
    parameter int QUEUE_DEPTH = 4
) (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               push,
    input logic                               pop,
    input logic                               empty,
    input logic                               ready,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0]   count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    assert property (@(posedge clk) disable iff (!rst_n) push |-> count != CNT_W'(QUEUE_DEPTH))
        else $error("push into a full load queue");

    assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("pop from an empty load queue");

    assert property (@(posedge clk) disable iff (!rst_n) count <= CNT_W'(QUEUE_DEPTH))
        else $error("load queue count above its depth");

    // a push comes from a load strobe raised while ready was high
    assert property (@(posedge clk) disable iff (!rst_n) push |-> $past(ready))
        else $error("load accepted while load_ready was low");

endmodule

bind load_queue load_read_path_assert #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) u_queue_assert (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (push),
    .pop   (pop),
    .empty (empty),
    .ready (ready),
    .count (count)
);

// File: sim/load_read_path_tb.sv
// testbench for the load read path: fills lines, runs a load table, checks results and faults
module load_read_path_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import line_pkg::*;
    import load_pkg::*;

    localparam int LINES       = 8;
    localparam int QUEUE_DEPTH = 4;
    localparam int INDEX_W     = $clog2(LINES);
    localparam int ADDR_W      = OFFSET_BITS + INDEX_W;
    localparam int TIMEOUT     = 200;
    localparam int NUM_LOADS   = 68;

    // hex digits per entry give fault expected, sign, size code and byte address
    localparam logic [19:0] LOAD_TABLE [NUM_LOADS] = '{
        // line 1 bytes zero extended
        20'h0_0_0_10, 20'h0_0_0_11, 20'h0_0_0_12, 20'h0_0_0_13, 20'h0_0_0_14, 20'h0_0_0_15,
        20'h0_0_0_16, 20'h0_0_0_17, 20'h0_0_0_18, 20'h0_0_0_19, 20'h0_0_0_1a, 20'h0_0_0_1b,
        20'h0_0_0_1c, 20'h0_0_0_1d, 20'h0_0_0_1e, 20'h0_0_0_1f,
        // line 1 bytes sign extended
        20'h0_1_0_10, 20'h0_1_0_11, 20'h0_1_0_12, 20'h0_1_0_13, 20'h0_1_0_14, 20'h0_1_0_15,
        20'h0_1_0_16, 20'h0_1_0_17, 20'h0_1_0_18, 20'h0_1_0_19, 20'h0_1_0_1a, 20'h0_1_0_1b,
        20'h0_1_0_1c, 20'h0_1_0_1d, 20'h0_1_0_1e, 20'h0_1_0_1f,
        // line 2 halfwords at even offsets
        20'h0_1_1_20, 20'h0_1_1_22, 20'h0_1_1_24, 20'h0_1_1_26, 20'h0_1_1_28, 20'h0_1_1_2a,
        20'h0_1_1_2c, 20'h0_1_1_2e, 20'h0_0_1_22, 20'h0_0_1_26, 20'h0_0_1_2a, 20'h0_0_1_2e,
        // line 3 words where the sign flag has no effect
        20'h0_0_2_30, 20'h0_0_2_34, 20'h0_0_2_38, 20'h0_0_2_3c, 20'h0_1_2_30, 20'h0_1_2_34,
        20'h0_1_2_38, 20'h0_1_2_3c,
        // misaligned and illegal size
        20'h1_0_1_21, 20'h1_1_1_2f, 20'h1_0_2_31, 20'h1_0_2_32, 20'h1_0_2_33, 20'h1_0_3_40,
        20'h1_1_3_44,
        // mixed burst over lines 4 to 7
        20'h0_1_2_40, 20'h0_1_1_52, 20'h0_1_0_6f, 20'h0_0_2_7c, 20'h1_0_1_75, 20'h0_0_1_46,
        20'h0_1_0_57, 20'h0_0_2_68, 20'h0_1_1_7e
    };

    logic                 clk;
    logic                 rst_n;
    logic                 fill_valid;
    logic [INDEX_W-1:0]   fill_index;
    logic [LINE_BITS-1:0] fill_line;
    logic                 load_valid;
    logic [ADDR_W-1:0]    load_addr;
    mem_size_e            load_size;
    logic                 load_sign;
    logic                 load_ready;
    logic                 result_valid;
    logic [31:0]          result_data;
    logic                 fault_valid;
    logic [ADDR_W-1:0]    fault_addr;
    fault_cause_e         fault_cause;

    logic [LINE_BITS-1:0] line_copy [LINES];
    logic [31:0]          lcg_state;
    logic [31:0]          data_q [$];
    logic [ADDR_W-1:0]    fault_addr_q [$];
    fault_cause_e         fault_cause_q [$];

    load_read_path #(
        .LINES       (LINES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .fill_valid   (fill_valid),
        .fill_index   (fill_index),
        .fill_line    (fill_line),
        .load_valid   (load_valid),
        .load_addr    (load_addr),
        .load_size    (load_size),
        .load_sign    (load_sign),
        .load_ready   (load_ready),
        .result_valid (result_valid),
        .result_data  (result_data),
        .fault_valid  (fault_valid),
        .fault_addr   (fault_addr),
        .fault_cause  (fault_cause)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // byte k of a line sits at bits 8k+7 down to 8k
    function automatic logic [31:0] model_load(input logic [LINE_BITS-1:0] line,
                                               input logic [OFFSET_BITS-1:0] offset,
                                               input mem_size_e size, input logic sign);
        logic [LINE_BITS-1:0] shifted;
        shifted = line >> (8 * offset);
        case (size)
            SIZE_BYTE: return sign ? {{24{shifted[7]}}, shifted[7:0]} : {24'h0, shifted[7:0]};
            SIZE_HALF: return sign ? {{16{shifted[15]}}, shifted[15:0]} : {16'h0, shifted[15:0]};
            default:   return shifted[31:0];
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error: time %0t: result_data %08h, expected %08h",
                                $time, actual, expected));
        end
    endtask

    task automatic check_fault(input logic [ADDR_W-1:0] addr, input fault_cause_e cause,
                               input logic [ADDR_W-1:0] exp_addr, input fault_cause_e exp_cause);
        if (addr !== exp_addr || cause !== exp_cause) begin
            abort_run($sformatf("Error: time %0t: fault %02h %s, expected %02h %s",
                                $time, addr, cause.name(), exp_addr, exp_cause.name()));
        end
    endtask

    // outputs settle after the rising edge and are sampled on the falling one
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            if (data_q.size() == 0) begin
                abort_run("result_valid pulsed with no load outstanding");
            end else begin
                check_data(result_data, data_q.pop_front());
            end
        end
        if (rst_n && fault_valid) begin
            if (fault_addr_q.size() == 0) begin
                abort_run("fault_valid pulsed for a load that should not fault");
            end else begin
                check_fault(fault_addr, fault_cause, fault_addr_q.pop_front(),
                            fault_cause_q.pop_front());
            end
        end
    end

    task automatic fill_all_lines();
        logic [LINE_BITS-1:0] data;
        for (int i = 0; i < LINES; i++) begin
            data = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
            fill_valid   = 1'b1;
            fill_index   = INDEX_W'(i);
            fill_line    = data;
            line_copy[i] = data;
            @(negedge clk);
        end
        fill_valid = 1'b0;
    endtask

    task automatic apply_load(input logic [19:0] entry);
        logic [ADDR_W-1:0] addr;
        mem_size_e         size;
        int                waited;
        addr   = entry[ADDR_W-1:0];
        size   = mem_size_e'(entry[9:8]);
        waited = 0;
        while (!load_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("load_ready stayed low too long");
            end
            @(negedge clk);
        end
        if (entry[16]) begin
            fault_addr_q.push_back(addr);
            // an illegal size code wins over misalignment
            if (entry[9:8] == 2'b11) begin
                fault_cause_q.push_back(FAULT_SIZE);
            end else begin
                fault_cause_q.push_back(FAULT_ALIGN);
            end
        end else begin
            data_q.push_back(model_load(line_copy[addr[ADDR_W-1:OFFSET_BITS]],
                                        addr[OFFSET_BITS-1:0], size, entry[12]));
        end
        load_valid = 1'b1;
        load_addr  = addr;
        load_size  = size;
        load_sign  = entry[12];
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (data_q.size() != 0 || fault_addr_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("result_valid or fault_valid never arrived for a pending load");
            end
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        lcg_state  = 32'h905bdcbd;
        rst_n      = 1'b0;
        fill_valid = 1'b0;
        fill_index = '0;
        fill_line  = '0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_size  = SIZE_BYTE;
        load_sign  = 1'b0;
        for (int i = 0; i < LINES; i++) begin
            line_copy[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (!load_ready) begin
            abort_run("load_ready is low after reset");
        end
        fill_all_lines();
        for (int i = 0; i < NUM_LOADS; i++) begin
            apply_load(LOAD_TABLE[i]);
        end
        wait_drained();
        // new contents everywhere then the same loads again
        fill_all_lines();
        for (int i = 0; i < NUM_LOADS; i++) begin
            apply_load(LOAD_TABLE[i]);
        end
        wait_drained();
        // idle cycles let a stray pulse reach the monitor
        repeat (4) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: files.f
hw/line_pkg.sv
hw/load_pkg.sv
hw/cache_read_formatter.sv
hw/load_issue.sv
hw/load_queue.sv
hw/line_store.sv
hw/load_format_stage.sv
hw/load_read_path.sv
sim/load_read_path_assert.sv
sim/load_read_path_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := load_read_path_tb
FILELIST   := files.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
